// ==== Makefile ====
# Verilator build and run of the loopback testbench

VERILATOR ?= verilator
TOP       ?= tb_uio_loop
FLIST     ?= uio_loop.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR VFLAGS"

$(SIM_BIN): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	if echo "$$out" | grep -qF "$(PASS_MSG)"; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR)

// ==== source/uio_csr.sv ====
`timescale 1ns/10ps

module uio_csr import uio_loop_pkg::*; (
   input  logic     clk_per,
   input  logic     i_rst_n,
   input  csr_req_t i_csr_req,
   output csr_rsp_t o_csr_rsp
);

   logic [CSR_DATA_W-1:0] scratch0;
   logic [CSR_DATA_W-1:0] scratch1;
   logic [CSR_DATA_W-1:0] rd_data_c;
   logic [CSR_DATA_W-1:0] rd_data_q;
   logic                  rd_ack_q;
   logic                  wr_scratch0;
   logic                  wr_scratch1;

   // Address decode
   assign wr_scratch0 = i_csr_req.wr_vld && (i_csr_req.addr == CSR_SCRATCH0);
   assign wr_scratch1 = i_csr_req.wr_vld && (i_csr_req.addr == CSR_SCRATCH1);

   // Read mux sees the register values before this edge's write
   always_comb begin
      case (i_csr_req.addr)
         CSR_SCRATCH0: begin
            rd_data_c = scratch0;
         end
         CSR_SCRATCH1: begin
            rd_data_c = scratch1;
         end
         default: begin
            rd_data_c = CSR_UNMAPPED;
         end
      endcase
   end

   always_ff @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         scratch0 <= '0;
         scratch1 <= '0;
         rd_ack_q <= 1'b0;
      end else begin
         if (wr_scratch0) begin
            scratch0 <= i_csr_req.wr_data;
         end
         if (wr_scratch1) begin
            scratch1 <= i_csr_req.wr_data;
         end
         // Every read is acknowledged whether mapped or not
         rd_ack_q <= i_csr_req.rd_vld;
      end
   end

   // Loaded only on reads and held between accesses
   always_ff @(posedge clk_per) begin
      if (i_csr_req.rd_vld) begin
         rd_data_q <= rd_data_c;
      end
   end

   assign o_csr_rsp.rd_data = rd_data_q;
   assign o_csr_rsp.rd_ack  = rd_ack_q;

endmodule

// ==== source/uio_fifo.sv ====
`timescale 1ns/10ps

module uio_fifo import uio_loop_pkg::*; (
   input  logic       clk_per,
   input  logic       i_rst_n,

   // Write side
   input  logic       i_push,
   input  port_word_t i_din,

   // Read side, head word shown without a pop
   input  logic       i_pop,
   output port_word_t o_dout,

   // Status
   output logic       o_empty,
   output logic       o_afull
);

   port_word_t            mem [FIFO_DEPTH];
   logic [FIFO_PTR_W-1:0] wr_ptr;
   logic [FIFO_PTR_W-1:0] rd_ptr;
   logic [FIFO_CNT_W-1:0] count;
   logic                  full;

   // Wrap at the last entry so the depth need not be a power of two
   function automatic logic [FIFO_PTR_W-1:0] ptr_next(input logic [FIFO_PTR_W-1:0] ptr);
      logic [FIFO_PTR_W-1:0] nxt;
      if (ptr == FIFO_PTR_LAST) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   // Storage
   always_ff @(posedge clk_per) begin
      if (i_push) begin
         mem[wr_ptr] <= i_din;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (i_push) begin
            wr_ptr <= ptr_next(wr_ptr);
         end
         if (i_pop) begin
            rd_ptr <= ptr_next(rd_ptr);
         end
         case ({i_push, i_pop})
            2'b10: begin
               count <= count + 1'b1;
            end
            2'b01: begin
               count <= count - 1'b1;
            end
            default: begin
               count <= count;
            end
         endcase
      end
   end

   // First word fall through
   assign o_dout  = mem[rd_ptr];

   assign o_empty = (count == '0);
   assign full    = (count == FIFO_CNT_W'(FIFO_DEPTH));
   assign o_afull = (count >= FIFO_CNT_W'(AFULL_LEVEL));

   // Writer must have honoured almost-full long before this
   a_no_overflow: assert property (
      @(posedge clk_per) disable iff (!i_rst_n)
      full |-> !i_push
   ) else $error("uio_fifo: push into a full FIFO");

   a_no_underflow: assert property (
      @(posedge clk_per) disable iff (!i_rst_n)
      o_empty |-> !i_pop
   ) else $error("uio_fifo: pop from an empty FIFO");

endmodule

// ==== source/uio_loop_pkg.sv ====
package uio_loop_pkg;

   // Channel count and word size
   localparam int NUM_PORTS = 4;
   localparam int PORT_W    = 32;

   // FIFO geometry
   localparam int FIFO_DEPTH = 16;
   localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
   localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

   localparam logic [FIFO_PTR_W-1:0] FIFO_PTR_LAST = FIFO_PTR_W'(FIFO_DEPTH - 1);

   // Upstream needs this many free slots to see almost-full and stop
   localparam int AFULL_MARGIN = 6;
   localparam int AFULL_LEVEL  = FIFO_DEPTH - AFULL_MARGIN;

   // CSR bus and register map
   localparam int CSR_ADDR_W = 16;
   localparam int CSR_DATA_W = 64;

   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH0 = 16'h0000;
   localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH1 = 16'h0008;

   // Returned for any read outside the map
   localparam logic [CSR_DATA_W-1:0] CSR_UNMAPPED = 64'hdead_beef_dead_beef;

   typedef logic [PORT_W-1:0] port_word_t;

   // One word on a channel, same shape for request and response
   typedef struct packed {
      logic       vld;
      port_word_t data;
   } port_beat_t;

   typedef struct packed {
      logic [CSR_ADDR_W-1:0] addr;
      logic [CSR_DATA_W-1:0] wr_data;
      logic                  wr_vld;
      logic                  rd_vld;
   } csr_req_t;

   typedef struct packed {
      logic [CSR_DATA_W-1:0] rd_data;
      logic                  rd_ack;
   } csr_rsp_t;

endpackage

// ==== source/uio_loop_top.sv ====
`timescale 1ns/10ps

module uio_loop_top import uio_loop_pkg::*; (
   input  logic                       clk_per,
   input  logic                       i_rst_n,

   // Request side, one beat per channel
   input  port_beat_t [NUM_PORTS-1:0] i_rq,
   output logic       [NUM_PORTS-1:0] o_rq_afull,

   // Response side
   output port_beat_t [NUM_PORTS-1:0] o_rs,
   input  logic       [NUM_PORTS-1:0] i_rs_afull,

   // Scratch register access
   input  csr_req_t                   i_csr_req,
   output csr_rsp_t                   o_csr_rsp
);

   genvar p;

   // Channels share nothing but clock and reset
   generate
      for (p = 0; p < NUM_PORTS; p++) begin : g_port
         uio_port_loop port_loop_i (
            .clk_per    (clk_per),
            .i_rst_n    (i_rst_n),
            .i_rq       (i_rq[p]),
            .o_rq_afull (o_rq_afull[p]),
            .o_rs       (o_rs[p]),
            .i_rs_afull (i_rs_afull[p])
         );
      end
   endgenerate

   uio_csr csr_i (
      .clk_per   (clk_per),
      .i_rst_n   (i_rst_n),
      .i_csr_req (i_csr_req),
      .o_csr_rsp (o_csr_rsp)
   );

endmodule

// ==== source/uio_port_loop.sv ====
`timescale 1ns/10ps

module uio_port_loop import uio_loop_pkg::*; (
   input  logic       clk_per,
   input  logic       i_rst_n,

   // Request side
   input  port_beat_t i_rq,
   output logic       o_rq_afull,

   // Response side
   output port_beat_t o_rs,
   input  logic       i_rs_afull
);

   logic       mid_empty;
   logic       mid_xfer;
   port_word_t mid_data;

   logic       rs_fifo_afull;
   logic       rs_empty;
   port_word_t rs_data;
   logic       rs_vld;

   // Move a word whenever the response FIFO still has room above its mark
   assign mid_xfer = !mid_empty && !rs_fifo_afull;

   uio_fifo rq_fifo_i (
      .clk_per (clk_per),
      .i_rst_n (i_rst_n),
      .i_push  (i_rq.vld),
      .i_din   (i_rq.data),
      .i_pop   (mid_xfer),
      .o_dout  (mid_data),
      .o_empty (mid_empty),
      .o_afull (o_rq_afull)
   );

   uio_fifo rs_fifo_i (
      .clk_per (clk_per),
      .i_rst_n (i_rst_n),
      .i_push  (mid_xfer),
      .i_din   (mid_data),
      .i_pop   (rs_vld),
      .o_dout  (rs_data),
      .o_empty (rs_empty),
      .o_afull (rs_fifo_afull)
   );

   // Valid doubles as the pop so a stalled word stays at the head
   assign rs_vld = !rs_empty && !i_rs_afull;

   assign o_rs.vld  = rs_vld;
   assign o_rs.data = rs_data;

   // Head word must survive a stall cycle unchanged
   a_rs_hold: assert property (
      @(posedge clk_per) disable iff (!i_rst_n)
      (!rs_empty && i_rs_afull) |=> (!rs_empty && $stable(rs_data))
   ) else $error("uio_port_loop: stalled response word lost or changed");

endmodule

// ==== uio_loop.f ====
source/uio_loop_pkg.sv
source/uio_fifo.sv
source/uio_port_loop.sv
source/uio_csr.sv
source/uio_loop_top.sv
verification/tb_clock_gen.sv
verification/tb_uio_checks.sv
verification/tb_uio_loop.sv

// ==== verification/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst_n
);

   localparam int RESET_CYCLES = 8;

   initial begin
      o_clk   = 1'b0;
      o_rst_n = 1'b0;
   end

   // 10 ns period
   always #5 o_clk = ~o_clk;

   initial begin
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

endmodule

// ==== verification/tb_uio_checks.sv ====
`timescale 1ns/10ps

module tb_uio_checks import uio_loop_pkg::*; (
   input  logic                       clk_per,
   input  logic                       i_rst_n,
   input  port_beat_t [NUM_PORTS-1:0] i_rq,
   input  logic       [NUM_PORTS-1:0] i_rq_afull,
   input  port_beat_t [NUM_PORTS-1:0] i_rs,
   input  logic       [NUM_PORTS-1:0] i_rs_afull,
   input  csr_req_t                   i_csr_req,
   input  csr_rsp_t                   i_csr_rsp,
   input  int                         i_test_id,
   output logic                       o_idle,
   output logic                       o_error
);

   // Words accepted but not yet returned on each channel
   port_word_t            sb_q [NUM_PORTS][$];
   port_word_t            head_word [NUM_PORTS];
   int                    sb_count [NUM_PORTS];
   logic [NUM_PORTS-1:0]  rs_vld;
   logic [CSR_DATA_W-1:0] model0;
   logic [CSR_DATA_W-1:0] model1;
   logic [CSR_DATA_W-1:0] exp_rd_q;
   int                    error_count = 0;

   assign o_error = (error_count != 0);

   function automatic string test_name(input int id);
      string name;
      case (id)
         1: name = "order";
         2: name = "latency";
         3: name = "backpressure";
         4: name = "independence";
         5: name = "scratch";
         6: name = "unmapped";
         default: name = "reset";
      endcase
      return name;
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] exp_val,
                                  input logic [63:0] act_val);
      $display("mismatch in test %s, %s: expected %0h, actual %0h",
               test_name(i_test_id), what, exp_val, act_val);
      error_count++;
   endtask

   task automatic report_failure(input string what);
      $display("Check failed in test %s: %s", test_name(i_test_id), what);
      error_count++;
   endtask

   // Pop before push as a word never returns in its own cycle
   always @(posedge clk_per or negedge i_rst_n) begin
      logic idle;
      if (!i_rst_n) begin
         for (int p = 0; p < NUM_PORTS; p++) begin
            sb_q[p].delete();
            sb_count[p]  <= 0;
            head_word[p] <= '0;
         end
         o_idle <= 1'b1;
      end else begin
         idle = 1'b1;
         for (int p = 0; p < NUM_PORTS; p++) begin
            if (i_rs[p].vld && sb_q[p].size() > 0) begin
               void'(sb_q[p].pop_front());
            end
            if (i_rq[p].vld) begin
               sb_q[p].push_back(i_rq[p].data);
            end
            sb_count[p]  <= sb_q[p].size();
            head_word[p] <= (sb_q[p].size() > 0) ? sb_q[p][0] : '0;
            if (sb_q[p].size() != 0) begin
               idle = 1'b0;
            end
         end
         o_idle <= idle;
      end
   end

   // Reference model of the scratch registers
   always @(posedge clk_per or negedge i_rst_n) begin
      if (!i_rst_n) begin
         model0   = '0;
         model1   = '0;
         exp_rd_q = '0;
      end else begin
         if (i_csr_req.rd_vld) begin
            if (i_csr_req.addr == CSR_SCRATCH0) begin
               exp_rd_q = model0;
            end else if (i_csr_req.addr == CSR_SCRATCH1) begin
               exp_rd_q = model1;
            end else begin
               exp_rd_q = CSR_UNMAPPED;
            end
         end
         if (i_csr_req.wr_vld && i_csr_req.addr == CSR_SCRATCH0) begin
            model0 = i_csr_req.wr_data;
         end
         if (i_csr_req.wr_vld && i_csr_req.addr == CSR_SCRATCH1) begin
            model1 = i_csr_req.wr_data;
         end
      end
   end

   for (genvar p = 0; p < NUM_PORTS; p++) begin : g_chk
      assign rs_vld[p] = i_rs[p].vld;

      a_order: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         (i_rs[p].vld && sb_count[p] > 0) |-> (i_rs[p].data == head_word[p])
      ) else report_mismatch("response word", 64'($sampled(head_word[p])),
                             64'($sampled(i_rs[p].data)));

      a_no_extra: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         i_rs[p].vld |-> (sb_count[p] > 0)
      ) else report_failure("response word without a matching request");

      // Lone word on an idle channel is valid two edges later
      a_latency: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         (i_rq[p].vld && sb_count[p] == 0 && !i_rs_afull[p])
            |=> !i_rs[p].vld ##1 (i_rs_afull[p] || i_rs[p].vld)
      ) else report_mismatch("response valid", 64'(!$sampled(i_rs[p].vld)),
                             64'($sampled(i_rs[p].vld)));

      a_stall: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         i_rs_afull[p] |-> !i_rs[p].vld
      ) else report_mismatch("stalled response valid", 64'd0, 64'd1);

      a_afull_low: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         (sb_count[p] < AFULL_LEVEL) |-> !i_rq_afull[p]
      ) else report_mismatch("request almost-full", 64'd0, 64'd1);

      a_afull_high: assert property (
         @(posedge clk_per) disable iff (!i_rst_n)
         (sb_count[p] >= 2 * AFULL_LEVEL) |-> i_rq_afull[p]
      ) else report_mismatch("request almost-full", 64'd1, 64'd0);
   end

   a_csr_read: assert property (
      @(posedge clk_per) disable iff (!i_rst_n)
      i_csr_req.rd_vld |=> (i_csr_rsp.rd_ack && i_csr_rsp.rd_data == exp_rd_q)
   ) else report_mismatch("csr read data", $sampled(exp_rd_q),
                          $sampled(i_csr_rsp.rd_data));

   a_csr_no_ack: assert property (
      @(posedge clk_per) disable iff (!i_rst_n)
      !i_csr_req.rd_vld |=> !i_csr_rsp.rd_ack
   ) else report_failure("csr acknowledge without a read");

   a_reset_quiet: assert property (
      @(posedge clk_per)
      $rose(i_rst_n) |-> (rs_vld == '0 && i_rq_afull == '0 && !i_csr_rsp.rd_ack)
   ) else report_failure("outputs not idle after reset");

endmodule

// ==== verification/tb_uio_loop.sv ====
`timescale 1ns/10ps

module tb_uio_loop import uio_loop_pkg::*; ();

   localparam int ORDER_CYCLES   = 3000;
   localparam int OTHER_CYCLES   = 600;
   localparam int TIMEOUT_CYCLES = 2 * (ORDER_CYCLES + OTHER_CYCLES) + 500;

   logic                       clk_per;
   logic                       rst_n;
   port_beat_t [NUM_PORTS-1:0] rq;
   logic       [NUM_PORTS-1:0] rq_afull;
   port_beat_t [NUM_PORTS-1:0] rs;
   logic       [NUM_PORTS-1:0] rs_afull;
   csr_req_t                   csr_req;
   csr_rsp_t                   csr_rsp;
   int                         test_id;
   logic                       sb_idle;
   logic                       check_error;
   logic [31:0]                lcg_state;

   tb_clock_gen clock_gen_i (
      .o_clk   (clk_per),
      .o_rst_n (rst_n)
   );

   uio_loop_top uio_loop_top_i (
      .clk_per    (clk_per),
      .i_rst_n    (rst_n),
      .i_rq       (rq),
      .o_rq_afull (rq_afull),
      .o_rs       (rs),
      .i_rs_afull (rs_afull),
      .i_csr_req  (csr_req),
      .o_csr_rsp  (csr_rsp)
   );

   tb_uio_checks checks_i (
      .clk_per    (clk_per),
      .i_rst_n    (rst_n),
      .i_rq       (rq),
      .i_rq_afull (rq_afull),
      .i_rs       (rs),
      .i_rs_afull (rs_afull),
      .i_csr_req  (csr_req),
      .i_csr_rsp  (csr_rsp),
      .i_test_id  (test_id),
      .o_idle     (sb_idle),
      .o_error    (check_error)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic next_rand(output logic [31:0] r);
      lcg_state = lcg_step(lcg_state);
      r = lcg_state;
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failures found");
      $fatal(1, "run stopped");
   endtask

   // Idle flag lags one edge behind the last accepted word
   task automatic wait_drained();
      @(posedge clk_per);
      while (!sb_idle) begin
         @(posedge clk_per);
      end
   endtask

   task automatic random_beat(input logic vld, output port_beat_t beat);
      logic [31:0] r;
      next_rand(r);
      beat.vld  = vld;
      beat.data = r;
   endtask

   // Random data, gaps and short stalls on all channels
   task automatic run_order(input int cycles);
      logic [31:0] r;
      port_beat_t  beat;
      for (int c = 0; c < cycles; c++) begin
         @(posedge clk_per);
         for (int p = 0; p < NUM_PORTS; p++) begin
            next_rand(r);
            random_beat((r[1:0] != 2'd0) && !rq_afull[p], beat);
            rq[p]       <= beat;
            rs_afull[p] <= (r[7:4] == 4'd0);
         end
      end
      @(posedge clk_per);
      rq       <= '0;
      rs_afull <= '0;
      wait_drained();
   endtask

   task automatic csr_access(input logic wr, input logic rd, input logic [15:0] addr,
                             input logic [63:0] data);
      csr_req_t req;
      req.addr    = addr;
      req.wr_data = data;
      req.wr_vld  = wr;
      req.rd_vld  = rd;
      @(posedge clk_per);
      csr_req <= req;
      @(posedge clk_per);
      csr_req <= '0;
      // Acknowledge lands one cycle after the request
      @(posedge clk_per);
   endtask

   always @(posedge check_error) begin
      fail_run("A check reported an error");
   end

   initial begin
      #(TIMEOUT_CYCLES * 10);
      fail_run("Timeout, the tests did not finish in time");
   end

   initial begin
      port_beat_t  beat;
      logic [31:0] r;
      logic [31:0] r2;
      logic [15:0] addr;
      lcg_state = 32'hd639_d6ba;
      rq        = '0;
      rs_afull  = '0;
      csr_req   = '0;
      test_id   = 0;
      @(posedge rst_n);
      repeat (3) @(posedge clk_per);

      test_id = 1;
      run_order(ORDER_CYCLES);

      test_id = 2;
      for (int p = 0; p < NUM_PORTS; p++) begin
         @(posedge clk_per);
         random_beat(1'b1, beat);
         rq[p] <= beat;
         @(posedge clk_per);
         rq[p] <= '0;
         repeat (4) @(posedge clk_per);
      end

      // Hold channel 3 until both FIFOs back up
      test_id = 3;
      @(posedge clk_per);
      rs_afull[3] <= 1'b1;
      for (int i = 0; i < 22; i++) begin
         @(posedge clk_per);
         random_beat(1'b1, beat);
         rq[3] <= beat;
      end
      @(posedge clk_per);
      rq[3] <= '0;
      repeat (10) @(posedge clk_per);
      rs_afull[3] <= 1'b0;
      wait_drained();

      // Channel 1 stalled while channel 0 sends lone words
      test_id = 4;
      @(posedge clk_per);
      rs_afull[1] <= 1'b1;
      for (int i = 0; i < 16; i++) begin
         @(posedge clk_per);
         random_beat(i < 12, beat);
         rq[1] <= beat;
         random_beat((i % 4) == 0, beat);
         rq[0] <= beat;
      end
      @(posedge clk_per);
      rq          <= '0;
      rs_afull[1] <= 1'b0;
      wait_drained();

      test_id = 5;
      csr_access(1'b0, 1'b1, CSR_SCRATCH0, '0);
      csr_access(1'b0, 1'b1, CSR_SCRATCH1, '0);
      next_rand(r);
      next_rand(r2);
      csr_access(1'b1, 1'b0, CSR_SCRATCH0, {r, r2});
      next_rand(r);
      csr_access(1'b1, 1'b0, CSR_SCRATCH1, {r2, r});
      csr_access(1'b0, 1'b1, CSR_SCRATCH0, '0);
      csr_access(1'b0, 1'b1, CSR_SCRATCH1, '0);
      next_rand(r);
      csr_access(1'b1, 1'b1, CSR_SCRATCH1, {r, ~r});
      csr_access(1'b0, 1'b1, CSR_SCRATCH1, '0);

      test_id = 6;
      for (int i = 0; i < 8; i++) begin
         next_rand(r);
         addr = r[15:0];
         if (addr == CSR_SCRATCH0 || addr == CSR_SCRATCH1) begin
            addr = addr | 16'h0100;
         end
         csr_access(1'b0, 1'b1, addr, '0);
         next_rand(r2);
         csr_access(1'b1, 1'b0, addr, {r2, r});
      end
      csr_access(1'b0, 1'b1, CSR_SCRATCH0, '0);
      csr_access(1'b0, 1'b1, CSR_SCRATCH1, '0);

      repeat (5) @(posedge clk_per);
      if (check_error) begin
         fail_run("Checks reported errors");
      end else begin
         $display("All tests passed!");
         $finish;
      end
   end

endmodule
